//--- verilog/rv32i_macros.svh
/*
 * RV32I core constants
 * Widths, reset vector and the no-op word shared by the RTL
 */

`default_nettype none

`ifndef RV32I_MACROS_SVH
`define RV32I_MACROS_SVH

// Data and address width
`define RV32I_XLEN          32

// Register index width
`define RV32I_REG_IDX_W     5

// First fetch address after reset
`define RV32I_RESET_VECTOR  32'h0000_0000

// ADDI x0,x0,0
`define RV32I_NOP           32'h0000_0013

`endif

`default_nettype wire

//--- verilog/rv32i_pkg.sv
/*
 * RV32I core types
 * Major opcodes, ALU operations, branch conditions and access widths
 */

`default_nettype none

package rv32i_pkg;

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_t;

  // Values follow funct3, NONE sits in an unused slot
  typedef enum logic [2:0] {
    BR_EQ   = 3'b000,
    BR_NE   = 3'b001,
    BR_NONE = 3'b010,
    BR_LT   = 3'b100,
    BR_GE   = 3'b101,
    BR_LTU  = 3'b110,
    BR_GEU  = 3'b111
  } branch_cond_t;

  // Matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    MEM_BYTE = 2'b00,
    MEM_HALF = 2'b01,
    MEM_WORD = 2'b10
  } mem_width_t;

endpackage

`default_nettype wire

//--- verilog/rv32i_exec_if.sv
/*
 * Decode to execute bus
 * One decoded instruction with its operands and controls
 */

`include "rv32i_macros.svh"

`default_nettype none
`timescale 1ns/100ps

interface rv32i_exec_if;

  logic                          valid;
  logic [`RV32I_XLEN-1:0]        a;
  logic [`RV32I_XLEN-1:0]        b;
  logic [`RV32I_XLEN-1:0]        offset;
  logic [`RV32I_XLEN-1:0]        pc;
  logic [`RV32I_REG_IDX_W-1:0]   rd;
  rv32i_pkg::alu_op_t            alu_op;
  rv32i_pkg::branch_cond_t       branch_cond;
  logic                          is_jump;
  logic                          is_load;
  logic                          is_store;
  rv32i_pkg::mem_width_t         mem_width;
  logic                          mem_unsigned;

  modport decode (output valid, a, b, offset, pc, rd, alu_op, branch_cond,
                  is_jump, is_load, is_store, mem_width, mem_unsigned);

  modport execute (input valid, a, b, offset, pc, rd, alu_op, branch_cond,
                   is_jump, is_load, is_store, mem_width, mem_unsigned);

endinterface

`default_nettype wire

//--- verilog/rv32i_decode.sv
/*
 * RV32I instruction decoder
 * Splits the fetched word into operands and controls for execute,
 * forwards writeback results and drops slots behind a taken branch
 */

`include "rv32i_macros.svh"

`default_nettype none
`timescale 1ns/100ps

module rv32i_decode
(
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic [`RV32I_XLEN-1:0]        instr,
  input  logic                          stall,
  input  logic                          update_pc,
  input  logic [`RV32I_XLEN-1:0]        pc,
  input  logic [`RV32I_XLEN-1:0]        rs1,
  input  logic [`RV32I_XLEN-1:0]        rs2,
  input  logic [`RV32I_REG_IDX_W-1:0]   wb_rd,
  input  logic [`RV32I_XLEN-1:0]        wb_val,
  output logic [`RV32I_REG_IDX_W-1:0]   rs1_idx,
  output logic [`RV32I_REG_IDX_W-1:0]   rs2_idx,
  rv32i_exec_if.decode                  exec
);

  logic                          stalled_q;
  logic                          word_ok_q;
  logic                          valid_q;
  logic [`RV32I_XLEN-1:0]        instr_hold;
  logic [`RV32I_XLEN-1:0]        instr_cur;
  logic [`RV32I_XLEN-1:0]        op_word;
  logic [2:0]                    funct3;

  // Registered operands, re-checked against writeback in execute
  logic [`RV32I_XLEN-1:0]        a_q;
  logic [`RV32I_XLEN-1:0]        b_q;
  logic [`RV32I_REG_IDX_W-1:0]   rs1_q;
  logic [`RV32I_REG_IDX_W-1:0]   rs2_q;
  logic                          a_reg_q;
  logic                          b_reg_q;

  logic [`RV32I_XLEN-1:0]        imm_i;
  logic [`RV32I_XLEN-1:0]        imm_s;
  logic [`RV32I_XLEN-1:0]        imm_b;
  logic [`RV32I_XLEN-1:0]        imm_u;
  logic [`RV32I_XLEN-1:0]        imm_j;
  logic [`RV32I_XLEN-1:0]        rs1_fwd;
  logic [`RV32I_XLEN-1:0]        rs2_fwd;
  logic [`RV32I_XLEN-1:0]        a_d;
  logic [`RV32I_XLEN-1:0]        b_d;
  logic [`RV32I_XLEN-1:0]        offset_d;
  logic                          a_reg_d;
  logic                          b_reg_d;
  logic [`RV32I_REG_IDX_W-1:0]   rd_d;
  rv32i_pkg::alu_op_t            alu_op_d;
  rv32i_pkg::branch_cond_t       cond_d;
  logic                          jump_d;
  logic                          load_d;
  logic                          store_d;

  function automatic rv32i_pkg::alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
    rv32i_pkg::alu_op_t op;
    case (f3)
      3'b000:  op = alt ? rv32i_pkg::ALU_SUB : rv32i_pkg::ALU_ADD;
      3'b001:  op = rv32i_pkg::ALU_SLL;
      3'b010:  op = rv32i_pkg::ALU_SLT;
      3'b011:  op = rv32i_pkg::ALU_SLTU;
      3'b100:  op = rv32i_pkg::ALU_XOR;
      3'b101:  op = alt ? rv32i_pkg::ALU_SRA : rv32i_pkg::ALU_SRL;
      3'b110:  op = rv32i_pkg::ALU_OR;
      default: op = rv32i_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  // ----------------------------------------
  // Instruction word selection
  // ----------------------------------------

  // Word is held while fetch is frozen, a flushed slot becomes a NOP
  assign instr_cur = stalled_q ? instr_hold : instr;
  assign op_word   = update_pc ? `RV32I_NOP : instr_cur;
  assign funct3    = op_word[14:12];
  assign rs1_idx   = op_word[19:15];
  assign rs2_idx   = op_word[24:20];

  assign imm_i = {{20{op_word[31]}}, op_word[31:20]};
  assign imm_s = {{20{op_word[31]}}, op_word[31:25], op_word[11:7]};
  assign imm_b = {{19{op_word[31]}}, op_word[31], op_word[7], op_word[30:25],
                  op_word[11:8], 1'b0};
  assign imm_u = {op_word[31:12], 12'h000};
  assign imm_j = {{11{op_word[31]}}, op_word[31], op_word[19:12], op_word[20],
                  op_word[30:21], 1'b0};

  // Result still on its way into the register file
  assign rs1_fwd = (wb_rd != '0 && wb_rd == rs1_idx) ? wb_val : rs1;
  assign rs2_fwd = (wb_rd != '0 && wb_rd == rs2_idx) ? wb_val : rs2;

  always_comb
  begin
    a_d      = rs1_fwd;
    a_reg_d  = 1'b1;
    b_d      = rs2_fwd;
    b_reg_d  = 1'b1;
    offset_d = imm_i;
    rd_d     = op_word[11:7];
    alu_op_d = rv32i_pkg::ALU_ADD;
    cond_d   = rv32i_pkg::BR_NONE;
    jump_d   = 1'b0;
    load_d   = 1'b0;
    store_d  = 1'b0;
    case (op_word[6:0])
      rv32i_pkg::OPC_LUI:
      begin
        a_d      = '0;
        a_reg_d  = 1'b0;
        b_d      = imm_u;
        b_reg_d  = 1'b0;
        alu_op_d = rv32i_pkg::ALU_PASS_B;
      end
      rv32i_pkg::OPC_AUIPC:
      begin
        a_d     = pc;
        a_reg_d = 1'b0;
        b_d     = imm_u;
        b_reg_d = 1'b0;
      end
      // JAL target comes from pc, JALR from rs1
      rv32i_pkg::OPC_JAL:
      begin
        a_d      = pc;
        a_reg_d  = 1'b0;
        offset_d = imm_j;
        jump_d   = 1'b1;
      end
      rv32i_pkg::OPC_JALR: jump_d = 1'b1;
      rv32i_pkg::OPC_BRANCH:
      begin
        offset_d = imm_b;
        rd_d     = '0;
        cond_d   = (funct3[2:1] == 2'b01) ? rv32i_pkg::BR_NONE :
                                            rv32i_pkg::branch_cond_t'(funct3);
      end
      rv32i_pkg::OPC_LOAD: load_d = 1'b1;
      rv32i_pkg::OPC_STORE:
      begin
        offset_d = imm_s;
        rd_d     = '0;
        store_d  = 1'b1;
      end
      rv32i_pkg::OPC_OP_IMM:
      begin
        b_d      = imm_i;
        b_reg_d  = 1'b0;
        alu_op_d = alu_sel(funct3, funct3 == 3'b101 && op_word[30]);
      end
      rv32i_pkg::OPC_OP: alu_op_d = alu_sel(funct3, op_word[30]);
      // FENCE, SYSTEM and the rest retire without effect
      default: rd_d = '0;
    endcase
  end

  // ----------------------------------------
  // Pipeline registers
  // ----------------------------------------

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      stalled_q <= 1'b0;
      word_ok_q <= 1'b0;
      valid_q   <= 1'b0;
    end
    else
    begin
      stalled_q <= stall;
      if (!stall)
      begin
        word_ok_q <= 1'b1;
        valid_q   <= word_ok_q & ~update_pc;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (stall)
    begin
      if (!stalled_q)
        instr_hold <= instr;
      // Keep any forwarded value once writeback moves on
      a_q <= exec.a;
      b_q <= exec.b;
    end
    else
    begin
      a_q               <= a_d;
      b_q               <= b_d;
      a_reg_q           <= a_reg_d;
      b_reg_q           <= b_reg_d;
      rs1_q             <= rs1_idx;
      rs2_q             <= rs2_idx;
      exec.offset       <= offset_d;
      exec.pc           <= pc;
      exec.rd           <= rd_d;
      exec.alu_op       <= alu_op_d;
      exec.branch_cond  <= cond_d;
      exec.is_jump      <= jump_d;
      exec.is_load      <= load_d;
      exec.is_store     <= store_d;
      exec.mem_width    <= funct3[1] ? rv32i_pkg::MEM_WORD :
                           (funct3[0] ? rv32i_pkg::MEM_HALF : rv32i_pkg::MEM_BYTE);
      exec.mem_unsigned <= funct3[2];
    end
  end

  // Second forwarding point covers the instruction just ahead
  assign exec.a     = (a_reg_q && wb_rd != '0 && rs1_q == wb_rd) ? wb_val : a_q;
  assign exec.b     = (b_reg_q && wb_rd != '0 && rs2_q == wb_rd) ? wb_val : b_q;
  // Slot already in execute is the first one flushed
  assign exec.valid = valid_q & ~update_pc;

endmodule

`default_nettype wire

//--- verilog/rv32i_regfile.sv
/*
 * RV32I register file
 * General registers x1 to x31 and the fetch program counter
 */

`include "rv32i_macros.svh"

`default_nettype none
`timescale 1ns/100ps

module rv32i_regfile
(
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic [`RV32I_REG_IDX_W-1:0]   rs1_idx,
  input  logic [`RV32I_REG_IDX_W-1:0]   rs2_idx,
  input  logic [`RV32I_REG_IDX_W-1:0]   wb_rd,
  input  logic [`RV32I_XLEN-1:0]        wb_val,
  input  logic                          update_pc,
  input  logic [`RV32I_XLEN-1:0]        new_pc,
  input  logic                          stall,
  output logic [`RV32I_XLEN-1:0]        rs1,
  output logic [`RV32I_XLEN-1:0]        rs2,
  output logic [`RV32I_XLEN-1:0]        pc,
  output logic [`RV32I_XLEN-1:0]        next_pc
);

  logic [`RV32I_XLEN-1:0] regs [1:(1 << `RV32I_REG_IDX_W)-1];

  // x0 has no storage
  assign rs1 = (rs1_idx == '0) ? '0 : regs[rs1_idx];
  assign rs2 = (rs2_idx == '0) ? '0 : regs[rs2_idx];

  always_ff @(posedge clk)
  begin
    if (wb_rd != '0)
      regs[wb_rd] <= wb_val;
  end

  // ----------------------------------------
  // Program counter
  // ----------------------------------------

  // next_pc is the fetch address, pc lags it by one fetch
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      next_pc <= `RV32I_RESET_VECTOR;
      pc      <= `RV32I_RESET_VECTOR;
    end
    else if (update_pc)
    begin
      next_pc <= new_pc + `RV32I_XLEN'd4;
      pc      <= new_pc;
    end
    else if (!stall)
    begin
      next_pc <= next_pc + `RV32I_XLEN'd4;
      pc      <= next_pc;
    end
  end

endmodule

`default_nettype wire

//--- verilog/rv32i_alu.sv
/*
 * RV32I execute stage
 * ALU, branch resolution, data memory access and register writeback
 */

`include "rv32i_macros.svh"

`default_nettype none
`timescale 1ns/100ps

module rv32i_alu
(
  input  logic                          clk,
  input  logic                          arst_n,
  rv32i_exec_if.execute                 exec,
  output logic [`RV32I_REG_IDX_W-1:0]   wb_rd,
  output logic [`RV32I_XLEN-1:0]        wb_val,
  output logic                          update_pc,
  output logic [`RV32I_XLEN-1:0]        new_pc,
  output logic                          stall,
  output logic [`RV32I_XLEN-1:0]        daddress,
  output logic                          dwrite,
  output logic [`RV32I_XLEN-1:0]        dwritedata,
  output logic [3:0]                    dbyteenable,
  output logic                          dread,
  input  logic [`RV32I_XLEN-1:0]        dreaddata,
  input  logic                          dwaitrequest
);

  logic [`RV32I_XLEN-1:0] result;
  logic [`RV32I_XLEN-1:0] addr_sum;
  logic [`RV32I_XLEN-1:0] target;
  logic [`RV32I_XLEN-1:0] ld_word;
  logic [`RV32I_XLEN-1:0] ld_ext;
  logic [1:0]             lane;
  logic [4:0]             shamt;
  logic                   taken;

  assign shamt = exec.b[4:0];

  always_comb
  begin
    case (exec.alu_op)
      rv32i_pkg::ALU_SUB:    result = exec.a - exec.b;
      rv32i_pkg::ALU_SLL:    result = exec.a << shamt;
      rv32i_pkg::ALU_SLT:    result = `RV32I_XLEN'($signed(exec.a) < $signed(exec.b));
      rv32i_pkg::ALU_SLTU:   result = `RV32I_XLEN'(exec.a < exec.b);
      rv32i_pkg::ALU_XOR:    result = exec.a ^ exec.b;
      rv32i_pkg::ALU_SRL:    result = exec.a >> shamt;
      rv32i_pkg::ALU_SRA:    result = $signed(exec.a) >>> shamt;
      rv32i_pkg::ALU_OR:     result = exec.a | exec.b;
      rv32i_pkg::ALU_AND:    result = exec.a & exec.b;
      rv32i_pkg::ALU_PASS_B: result = exec.b;
      default:               result = exec.a + exec.b;
    endcase
  end

  always_comb
  begin
    case (exec.branch_cond)
      rv32i_pkg::BR_EQ:  taken = (exec.a == exec.b);
      rv32i_pkg::BR_NE:  taken = (exec.a != exec.b);
      rv32i_pkg::BR_LT:  taken = ($signed(exec.a) < $signed(exec.b));
      rv32i_pkg::BR_GE:  taken = ($signed(exec.a) >= $signed(exec.b));
      rv32i_pkg::BR_LTU: taken = (exec.a < exec.b);
      rv32i_pkg::BR_GEU: taken = (exec.a >= exec.b);
      default:           taken = 1'b0;
    endcase
  end

  // Jumps use a + offset (a is pc for JAL), branches pc + offset
  assign addr_sum = exec.a + exec.offset;
  assign target   = exec.is_jump ? {addr_sum[`RV32I_XLEN-1:1], 1'b0} :
                                   exec.pc + exec.offset;

  // ----------------------------------------
  // Data memory access
  // ----------------------------------------

  assign daddress   = addr_sum;
  assign lane       = addr_sum[1:0];
  assign dread      = exec.valid & exec.is_load;
  assign dwrite     = exec.valid & exec.is_store;
  assign stall      = (dread | dwrite) & dwaitrequest;
  assign dwritedata = exec.b << {lane, 3'b000};

  always_comb
  begin
    case (exec.mem_width)
      rv32i_pkg::MEM_BYTE: dbyteenable = 4'b0001 << lane;
      rv32i_pkg::MEM_HALF: dbyteenable = 4'b0011 << lane;
      default:             dbyteenable = 4'b1111;
    endcase
  end

  // Bring the addressed lane down to bit 0, then extend
  assign ld_word = dreaddata >> {lane, 3'b000};

  always_comb
  begin
    case (exec.mem_width)
      rv32i_pkg::MEM_BYTE:
        ld_ext = {{(`RV32I_XLEN-8){~exec.mem_unsigned & ld_word[7]}}, ld_word[7:0]};
      rv32i_pkg::MEM_HALF:
        ld_ext = {{(`RV32I_XLEN-16){~exec.mem_unsigned & ld_word[15]}}, ld_word[15:0]};
      default:
        ld_ext = ld_word;
    endcase
  end

  // ----------------------------------------
  // Writeback and redirect
  // ----------------------------------------

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wb_rd     <= '0;
      update_pc <= 1'b0;
    end
    else
    begin
      update_pc <= exec.valid & (exec.is_jump | taken);
      // A waiting access retires only in its completing cycle
      if (exec.valid && !stall && !exec.is_store)
        wb_rd <= exec.rd;
      else
        wb_rd <= '0;
    end
  end

  always_ff @(posedge clk)
  begin
    new_pc <= target;
    if (exec.is_load)
      wb_val <= ld_ext;
    else if (exec.is_jump)
      wb_val <= exec.pc + `RV32I_XLEN'd4;
    else
      wb_val <= result;
  end

endmodule

`default_nettype wire

//--- verilog/rv32i_cpu_core.sv
/*
 * RV32I core top level
 * Joins decode, register file and execute, and drives the memory ports
 */

`include "rv32i_macros.svh"

`default_nettype none
`timescale 1ns/100ps

module rv32i_cpu_core
(
  input  logic                          clk,
  input  logic                          arst_n,
  output logic [`RV32I_XLEN-1:0]        iaddress,
  output logic                          iread,
  input  logic [`RV32I_XLEN-1:0]        ireaddata,
  output logic [`RV32I_XLEN-1:0]        daddress,
  output logic                          dwrite,
  output logic [`RV32I_XLEN-1:0]        dwritedata,
  output logic [3:0]                    dbyteenable,
  output logic                          dread,
  input  logic [`RV32I_XLEN-1:0]        dreaddata,
  input  logic                          dwaitrequest,
  output logic [`RV32I_REG_IDX_W-1:0]   test_rd_idx,
  output logic [`RV32I_XLEN-1:0]        test_rd_val
);

  rv32i_exec_if exec_bus ();

  logic                          run_q;
  logic                          fetch_stall;
  logic                          stall;
  logic                          update_pc;
  logic [`RV32I_XLEN-1:0]        new_pc;
  logic [`RV32I_XLEN-1:0]        dec_pc;
  logic [`RV32I_XLEN-1:0]        next_pc;
  logic [`RV32I_REG_IDX_W-1:0]   rs1_idx;
  logic [`RV32I_REG_IDX_W-1:0]   rs2_idx;
  logic [`RV32I_XLEN-1:0]        rs1;
  logic [`RV32I_XLEN-1:0]        rs2;
  logic [`RV32I_REG_IDX_W-1:0]   wb_rd;
  logic [`RV32I_XLEN-1:0]        wb_val;

  // Fetch starts on the first clock out of reset
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      run_q <= 1'b0;
    else
      run_q <= 1'b1;
  end

  assign fetch_stall = stall | ~run_q;
  assign iread       = ~fetch_stall;
  assign iaddress    = update_pc ? new_pc : next_pc;

  // Every register write goes out for checking
  assign test_rd_idx = wb_rd;
  assign test_rd_val = wb_val;

  rv32i_decode u_decode (
    .clk       (clk),
    .arst_n    (arst_n),
    .instr     (ireaddata),
    .stall     (fetch_stall),
    .update_pc (update_pc),
    .pc        (dec_pc),
    .rs1       (rs1),
    .rs2       (rs2),
    .wb_rd     (wb_rd),
    .wb_val    (wb_val),
    .rs1_idx   (rs1_idx),
    .rs2_idx   (rs2_idx),
    .exec      (exec_bus)
  );

  rv32i_regfile u_regfile (
    .clk       (clk),
    .arst_n    (arst_n),
    .rs1_idx   (rs1_idx),
    .rs2_idx   (rs2_idx),
    .wb_rd     (wb_rd),
    .wb_val    (wb_val),
    .update_pc (update_pc),
    .new_pc    (new_pc),
    .stall     (fetch_stall),
    .rs1       (rs1),
    .rs2       (rs2),
    .pc        (dec_pc),
    .next_pc   (next_pc)
  );

  rv32i_alu u_alu (
    .clk          (clk),
    .arst_n       (arst_n),
    .exec         (exec_bus),
    .wb_rd        (wb_rd),
    .wb_val       (wb_val),
    .update_pc    (update_pc),
    .new_pc       (new_pc),
    .stall        (stall),
    .daddress     (daddress),
    .dwrite       (dwrite),
    .dwritedata   (dwritedata),
    .dbyteenable  (dbyteenable),
    .dread        (dread),
    .dreaddata    (dreaddata),
    .dwaitrequest (dwaitrequest)
  );

endmodule

`default_nettype wire

//--- tests/rv32i_core_chk.sv
/*
 * RV32I core memory port checker
 * Concurrent assertions on the data strobes, bound to the core top level
 */

`default_nettype none
`timescale 1ns/100ps

module rv32i_core_chk
(
  input wire        clk,
  input wire        arst_n,
  input wire        dread,
  input wire        dwrite,
  input wire [3:0]  dbyteenable,
  input wire [31:0] daddress,
  input wire        dwaitrequest
);

  // One access type at a time
  a_no_read_write: assert property (@(posedge clk) disable iff (!arst_n)
    !(dread && dwrite))
    else $error("dread and dwrite high together");

  a_write_enables: assert property (@(posedge clk) disable iff (!arst_n)
    dwrite |-> (dbyteenable != 4'b0000))
    else $error("dwrite with no byte enabled");

  // A waiting access keeps strobe, address and enables
  a_hold_on_wait: assert property (@(posedge clk) disable iff (!arst_n)
    ((dread || dwrite) && dwaitrequest) |=>
      ($stable(dread) && $stable(dwrite) && $stable(daddress) && $stable(dbyteenable)))
    else $error("data access changed while dwaitrequest was high");

endmodule

bind rv32i_cpu_core rv32i_core_chk u_chk (.*);

`default_nettype wire

//--- tests/tb_rv32i_cpu_core.sv
/*
 * RV32I core testbench
 * Runs a program from a table with expected writebacks, models instruction
 * and data memory with random wait states, and checks the final data image
 */

`include "rv32i_macros.svh"

`default_nettype none
`timescale 1ns/100ps

module tb_rv32i_cpu_core;

  logic                          clk;
  logic                          arst_n;
  logic [`RV32I_XLEN-1:0]        iaddress;
  logic                          iread;
  logic [`RV32I_XLEN-1:0]        ireaddata;
  logic [`RV32I_XLEN-1:0]        daddress;
  logic                          dwrite;
  logic [`RV32I_XLEN-1:0]        dwritedata;
  logic [3:0]                    dbyteenable;
  logic                          dread;
  logic [`RV32I_XLEN-1:0]        dreaddata;
  logic                          dwaitrequest;
  logic [`RV32I_REG_IDX_W-1:0]   test_rd_idx;
  logic [`RV32I_XLEN-1:0]        test_rd_val;

  logic [31:0] prog [0:63];
  logic [31:0] dmem [0:255];
  logic [31:0] fetch_addr;
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_val [$];
  integer      prog_len;
  integer      seed;
  integer      waits;
  bit          busy;
  integer      errors;
  integer      checks;
  integer      tests;

  rv32i_cpu_core DUT (
    .clk          (clk),
    .arst_n       (arst_n),
    .iaddress     (iaddress),
    .iread        (iread),
    .ireaddata    (ireaddata),
    .daddress     (daddress),
    .dwrite       (dwrite),
    .dwritedata   (dwritedata),
    .dbyteenable  (dbyteenable),
    .dread        (dread),
    .dreaddata    (dreaddata),
    .dwaitrequest (dwaitrequest),
    .test_rd_idx  (test_rd_idx),
    .test_rd_val  (test_rd_val)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------
  // Instruction encoders
  // ----------------------------------------

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // Initial data word, built from every address bit of the word index
  function automatic logic [31:0] fill_word(input logic [7:0] idx);
    return {4{idx}} ^ 32'h5A5A_5A5A;
  endfunction

  // Program word plus its expected writeback, rd of zero means none
  task automatic add_instr(input logic [31:0] word, input logic [4:0] rd,
                           input logic [31:0] val);
    prog[prog_len] = word;
    prog_len = prog_len + 1;
    if (rd != 5'd0)
    begin
      exp_rd.push_back(rd);
      exp_val.push_back(val);
    end
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks = checks + 1;
    if (got !== exp)
    begin
      errors = errors + 1;
      $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
    end
  endtask

  task automatic wait_writeback(input integer limit, output bit found);
    integer n;
    found = 1'b0;
    n = 0;
    while (!found && n < limit)
    begin
      @(negedge clk);
      n = n + 1;
      if (test_rd_idx != '0)
        found = 1'b1;
    end
  endtask

  task automatic report(input string name, input integer errs_before);
    tests = tests + 1;
    $display("test %-22s %s", name, (errors == errs_before) ? "PASS" : "FAIL");
  endtask

  // ----------------------------------------
  // Memory models, driven on the falling edge
  // ----------------------------------------

  always @(negedge clk)
  begin
    ireaddata = prog[fetch_addr[7:2]];
    // Fetch address is taken only on a read strobe
    if (iread)
      fetch_addr = iaddress;
    if (dread || dwrite)
    begin
      if (!busy)
      begin
        waits = $unsigned($random(seed)) % 3;
        busy = 1'b1;
      end
      if (waits > 0)
      begin
        dwaitrequest = 1'b1;
        waits = waits - 1;
      end
      else
      begin
        dwaitrequest = 1'b0;
        busy = 1'b0;
        if (dwrite)
        begin
          for (int b = 0; b < 4; b++)
            if (dbyteenable[b])
              dmem[daddress[9:2]][8*b +: 8] = dwritedata[8*b +: 8];
        end
        else
          dreaddata = dmem[daddress[9:2]];
      end
    end
    else
      dwaitrequest = 1'b0;
  end

  // ----------------------------------------
  // Program table with expected writebacks
  // ----------------------------------------

  task automatic load_program;
    add_instr(i_type(12'd5, 5'd0, 3'b000, 5'd1, rv32i_pkg::OPC_OP_IMM), 5'd1, 32'd5);
    add_instr(i_type(12'hFFD, 5'd1, 3'b000, 5'd2, rv32i_pkg::OPC_OP_IMM), 5'd2, 32'd2);
    add_instr(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, 32'd7);
    add_instr(r_type(7'h20, 5'd1, 5'd2, 3'b000, 5'd4), 5'd4, 32'hFFFF_FFFD);
    add_instr(r_type(7'h00, 5'd1, 5'd4, 3'b010, 5'd5), 5'd5, 32'd1);
    add_instr(r_type(7'h00, 5'd1, 5'd4, 3'b011, 5'd6), 5'd6, 32'd0);
    add_instr(u_type(20'h12345, 5'd7, rv32i_pkg::OPC_LUI), 5'd7, 32'h1234_5000);
    add_instr(u_type(20'h00001, 5'd8, rv32i_pkg::OPC_AUIPC), 5'd8, 32'h0000_101C);
    add_instr(r_type(7'h00, 5'd2, 5'd1, 3'b001, 5'd9), 5'd9, 32'd20);
    add_instr(i_type(12'h401, 5'd4, 3'b101, 5'd10, rv32i_pkg::OPC_OP_IMM), 5'd10, 32'hFFFF_FFFE);
    add_instr(i_type(12'h01C, 5'd4, 3'b101, 5'd11, rv32i_pkg::OPC_OP_IMM), 5'd11, 32'h0000_000F);
    add_instr(r_type(7'h00, 5'd4, 5'd7, 3'b111, 5'd12), 5'd12, 32'h1234_5000);
    add_instr(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd13), 5'd13, 32'd7);
    add_instr(r_type(7'h00, 5'd1, 5'd3, 3'b100, 5'd14), 5'd14, 32'd2);
    // Write to x0 retires silently
    add_instr(i_type(12'd1, 5'd1, 3'b000, 5'd0, rv32i_pkg::OPC_OP_IMM), 5'd0, 32'd0);
    add_instr(b_type(13'd8, 5'd2, 5'd1, 3'b000), 5'd0, 32'd0);
    add_instr(b_type(13'd12, 5'd2, 5'd1, 3'b001), 5'd0, 32'd0);
    add_instr(i_type(12'd1, 5'd0, 3'b000, 5'd15, rv32i_pkg::OPC_OP_IMM), 5'd0, 32'd0);
    add_instr(i_type(12'd2, 5'd0, 3'b000, 5'd15, rv32i_pkg::OPC_OP_IMM), 5'd0, 32'd0);
    add_instr(j_type(21'd12, 5'd16), 5'd16, 32'd80);
    add_instr(i_type(12'd3, 5'd0, 3'b000, 5'd15, rv32i_pkg::OPC_OP_IMM), 5'd0, 32'd0);
    add_instr(i_type(12'd4, 5'd0, 3'b000, 5'd15, rv32i_pkg::OPC_OP_IMM), 5'd0, 32'd0);
    add_instr(i_type(12'd112, 5'd0, 3'b000, 5'd17, rv32i_pkg::OPC_OP_IMM), 5'd17, 32'd112);
    add_instr(i_type(12'd0, 5'd17, 3'b000, 5'd18, rv32i_pkg::OPC_JALR), 5'd18, 32'd96);
    for (int k = 0; k < 4; k++)
      add_instr(i_type(12'd5, 5'd0, 3'b000, 5'd15, rv32i_pkg::OPC_OP_IMM), 5'd0, 32'd0);
    // Branch block at 112
    add_instr(b_type(13'd8, 5'd1, 5'd4, 3'b100), 5'd0, 32'd0);
    add_instr(i_type(12'd6, 5'd0, 3'b000, 5'd15, rv32i_pkg::OPC_OP_IMM), 5'd0, 32'd0);
    add_instr(b_type(13'd8, 5'd1, 5'd4, 3'b110), 5'd0, 32'd0);
    add_instr(b_type(13'd8, 5'd4, 5'd1, 3'b101), 5'd0, 32'd0);
    add_instr(i_type(12'd7, 5'd0, 3'b000, 5'd15, rv32i_pkg::OPC_OP_IMM), 5'd0, 32'd0);
    // Stores and loads around 0x100
    add_instr(i_type(12'h100, 5'd0, 3'b000, 5'd20, rv32i_pkg::OPC_OP_IMM), 5'd20, 32'h100);
    add_instr(u_type(20'h87654, 5'd21, rv32i_pkg::OPC_LUI), 5'd21, 32'h8765_4000);
    add_instr(i_type(12'h321, 5'd21, 3'b000, 5'd21, rv32i_pkg::OPC_OP_IMM), 5'd21, 32'h8765_4321);
    add_instr(s_type(12'd0, 5'd21, 5'd20, 3'b010), 5'd0, 32'd0);
    add_instr(s_type(12'd4, 5'd4, 5'd20, 3'b001), 5'd0, 32'd0);
    add_instr(s_type(12'd7, 5'd1, 5'd20, 3'b000), 5'd0, 32'd0);
    add_instr(s_type(12'd9, 5'd21, 5'd20, 3'b000), 5'd0, 32'd0);
    add_instr(i_type(12'd0, 5'd20, 3'b010, 5'd22, rv32i_pkg::OPC_LOAD), 5'd22, 32'h8765_4321);
    add_instr(r_type(7'h00, 5'd1, 5'd22, 3'b000, 5'd23), 5'd23, 32'h8765_4326);
    add_instr(i_type(12'd2, 5'd20, 3'b001, 5'd24, rv32i_pkg::OPC_LOAD), 5'd24, 32'hFFFF_8765);
    add_instr(i_type(12'd2, 5'd20, 3'b101, 5'd25, rv32i_pkg::OPC_LOAD), 5'd25, 32'h0000_8765);
    add_instr(i_type(12'd3, 5'd20, 3'b000, 5'd26, rv32i_pkg::OPC_LOAD), 5'd26, 32'hFFFF_FF87);
    add_instr(i_type(12'd1, 5'd20, 3'b100, 5'd27, rv32i_pkg::OPC_LOAD), 5'd27, 32'h0000_0043);
    add_instr(i_type(12'd4, 5'd20, 3'b010, 5'd28, rv32i_pkg::OPC_LOAD), 5'd28, 32'h051B_FFFD);
    add_instr(i_type(12'd8, 5'd20, 3'b010, 5'd29, rv32i_pkg::OPC_LOAD), 5'd29, 32'h1818_2118);
    // Park in a self loop
    add_instr(b_type(13'd0, 5'd0, 5'd0, 3'b000), 5'd0, 32'd0);
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial
  begin
    integer      errs;
    integer      quiet;
    bit          found;
    logic [31:0] exp_word;
    arst_n       = 1'b0;
    ireaddata    = `RV32I_NOP;
    dreaddata    = '0;
    dwaitrequest = 1'b0;
    fetch_addr   = '0;
    seed         = 1849;
    waits        = 0;
    busy         = 1'b0;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    prog_len     = 0;
    for (int i = 0; i < 64; i++)
      prog[i] = `RV32I_NOP;
    for (int i = 0; i < 256; i++)
      dmem[i] = fill_word(i[7:0]);
    load_program();

    // Reset values, held and just after release
    errs = errors;
    for (int c = 0; c < 4; c++)
    begin
      @(negedge clk);
      compare("iaddress", iaddress, `RV32I_RESET_VECTOR);
      compare("iread", {31'd0, iread}, {31'd0, c == 3});
      compare("dread", {31'd0, dread}, 32'd0);
      compare("dwrite", {31'd0, dwrite}, 32'd0);
      compare("test_rd_idx", {27'd0, test_rd_idx}, 32'd0);
      if (c == 2)
        arst_n = 1'b1;
    end
    arst_n = 1'b1;
    report("reset", errs);

    // Writebacks in program order
    errs = errors;
    found = 1'b1;
    for (int e = 0; e < exp_rd.size() && found; e++)
    begin
      wait_writeback(100, found);
      if (!found)
      begin
        errors = errors + 1;
        $display("Timed out waiting for the writeback of x%0d", exp_rd[e]);
      end
      else
      begin
        compare("test_rd_idx", {27'd0, test_rd_idx}, {27'd0, exp_rd[e]});
        compare("test_rd_val", test_rd_val, exp_val[e]);
      end
    end
    report("writeback sequence", errs);

    // The self loop must stay silent
    errs = errors;
    for (quiet = 0; quiet < 30; quiet++)
    begin
      @(negedge clk);
      if (test_rd_idx != '0)
      begin
        errors = errors + 1;
        $display("Unexpected writeback to x%0d at time %0t", test_rd_idx, $time);
      end
    end
    report("no extra writeback", errs);

    errs = errors;
    for (int i = 0; i < 256; i++)
    begin
      exp_word = fill_word(i[7:0]);
      if (i == 8'h40)
        exp_word = 32'h8765_4321;
      else if (i == 8'h41)
        exp_word = 32'h051B_FFFD;
      else if (i == 8'h42)
        exp_word = 32'h1818_2118;
      compare($sformatf("dmem[%0d]", i), dmem[i], exp_word);
    end
    report("data memory image", errs);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+verilog
verilog/rv32i_pkg.sv
verilog/rv32i_exec_if.sv
verilog/rv32i_decode.sv
verilog/rv32i_regfile.sv
verilog/rv32i_alu.sv
verilog/rv32i_cpu_core.sv
tests/rv32i_core_chk.sv
tests/tb_rv32i_cpu_core.sv
